// File: common/mel_pkg.sv
package mel_pkg;

  // bin word and power width.
  localparam int BIN_W = 32;

  // width of each signed half of a complex bin.
  localparam int HALF_W = 16;

  // unsigned Q1.15 mel coefficients.
  localparam int COEFF_W = 16;
  localparam int COEFF_FRAC = 15;

  // filter energy after the product sum drops its coefficient fraction.
  localparam int ENERGY_W = 40;

  // log2 output: integer part holds the leading-one position.
  localparam int LOG_W = 16;
  localparam int LOG_FRAC = 10;
  localparam int LOG_INT_W = LOG_W - LOG_FRAC;

  // frame-wide input mode flag.
  localparam logic MODE_COMPLEX = 1'b0;
  localparam logic MODE_POWER = 1'b1;

  // one input word, read either as a complex bin or as a finished power.
  typedef union packed {
    struct packed {
      logic signed [HALF_W-1:0] re;
      logic signed [HALF_W-1:0] im;
    } cplx;
    logic [BIN_W-1:0] pwr;
  } bin_word_t;

endpackage

// File: verilog/bin_power.sv
`timescale 1ns/1ps

module bin_power (
  input  logic                      clk,
  input  logic                      rst,
  input  mel_pkg::bin_word_t        bin_in,
  input  logic                      bin_mode,
  input  logic                      bin_valid,
  output logic [mel_pkg::BIN_W-1:0] power,
  output logic                      power_valid
);

  import mel_pkg::*;

  logic signed [BIN_W-1:0] re_sq;
  logic signed [BIN_W-1:0] im_sq;
  logic [BIN_W-1:0] cplx_power;
  logic [BIN_W-1:0] next_power;

  // both squares are at most 2^30, so their sum fits in 32 unsigned bits.
  assign re_sq = bin_in.cplx.re * bin_in.cplx.re;
  assign im_sq = bin_in.cplx.im * bin_in.cplx.im;
  assign cplx_power = $unsigned(re_sq) + $unsigned(im_sq);

  // power mode passes the word through untouched.
  assign next_power = (bin_mode == MODE_COMPLEX) ? cplx_power : bin_in.pwr;

  always_ff @(posedge clk) begin
    if (rst) begin
      power_valid <= 1'b0;
    end else begin
      power_valid <= bin_valid;
    end
  end

  // payload only moves when a bin is taken.
  always_ff @(posedge clk) begin
    if (bin_valid) begin
      power <= next_power;
    end
  end

endmodule

// File: mel_filterbank/mel_coeff_rom.sv
`timescale 1ns/1ps

module mel_coeff_rom #(
  parameter int NUM_FILTERS = 40,
  parameter int FILTER_SIZE = 23
) (
  input  logic                          clk,
  input  logic [$clog2(NUM_FILTERS)-1:0] filter_idx,
  input  logic [$clog2(FILTER_SIZE)-1:0] coeff_idx,
  output logic [mel_pkg::COEFF_W-1:0]    coeff
);

  import mel_pkg::*;

  // three filter bands, each with its own taper over the bins.
  function automatic logic [COEFF_W-1:0] band_coeff(input int f, input int b);
    if (f < NUM_FILTERS / 4) begin
      if (b < 10) return 16'h7FFF;
      if (b < 20) return 16'h4000;
      return 16'h1000;
    end
    if (f < (3 * NUM_FILTERS) / 4) begin
      if (b < 5) return 16'h7FFF;
      if (b < 15) return 16'h6000;
      return 16'h2000;
    end
    if (b < 3) return 16'h7FFF;
    if (b < 8) return 16'h5000;
    return 16'h3000;
  endfunction

  // one cycle of read latency.
  always_ff @(posedge clk) begin
    coeff <= band_coeff(int'(filter_idx), int'(coeff_idx));
  end

  // the bin address must never run past the frame.
  a_coeff_idx_range : assert property (
    @(posedge clk) !$isunknown(coeff_idx) |-> (int'(coeff_idx) < FILTER_SIZE)
  );

endmodule

// File: mel_filterbank/mel_filterbank.sv
`timescale 1ns/1ps

module mel_filterbank #(
  parameter int NUM_FILTERS = 40,
  parameter int FILTER_SIZE = 23
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [mel_pkg::BIN_W-1:0]    power,
  input  logic                         power_valid,
  output logic                         bin_ready,
  output logic [mel_pkg::ENERGY_W-1:0] energy,
  output logic                         energy_valid
);

  import mel_pkg::*;

  localparam int FIDX_W = $clog2(NUM_FILTERS);
  localparam int BIDX_W = $clog2(FILTER_SIZE);
  localparam int PROD_W = BIN_W + COEFF_W;
  localparam int ACC_W = ENERGY_W + COEFF_FRAC;

  localparam logic FILL = 1'b0;
  localparam logic SWEEP = 1'b1;

  logic state;
  logic [BIDX_W-1:0] fill_cnt;
  logic fill_last;

  logic [BIN_W-1:0] frame_buf [FILTER_SIZE];

  // sweep address counters.
  logic addr_active;
  logic [FIDX_W-1:0] filt_cnt;
  logic [BIDX_W-1:0] bin_cnt;
  logic addr_last;
  logic addr_final;

  // stage 1 holds buffer data next to the registered coefficient.
  logic s1_valid;
  logic s1_last;
  logic s1_final;
  logic [BIN_W-1:0] s1_power;
  logic [COEFF_W-1:0] coeff;

  // stage 2 holds the full-width product.
  logic s2_valid;
  logic s2_last;
  logic s2_final;
  logic [PROD_W-1:0] s2_prod;

  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] acc_sum;
  logic energy_final;

  assign fill_last = (fill_cnt == BIDX_W'(FILTER_SIZE - 1));
  assign addr_last = (bin_cnt == BIDX_W'(FILTER_SIZE - 1));
  assign addr_final = addr_last && (filt_cnt == FIDX_W'(NUM_FILTERS - 1));
  assign acc_sum = acc + ACC_W'(s2_prod);

  // ready drops as soon as the last bin of the frame has been taken upstream.
  assign bin_ready = (state == FILL) && !(power_valid && fill_last);

  mel_coeff_rom #(
    .NUM_FILTERS(NUM_FILTERS),
    .FILTER_SIZE(FILTER_SIZE)
  ) mel_coeff_rom_inst (
    .clk       (clk),
    .filter_idx(filt_cnt),
    .coeff_idx (bin_cnt),
    .coeff     (coeff)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FILL;
      fill_cnt <= '0;
      addr_active <= 1'b0;
      filt_cnt <= '0;
      bin_cnt <= '0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      acc <= '0;
      energy_valid <= 1'b0;
    end else begin
      s1_valid <= addr_active;
      s2_valid <= s1_valid;
      energy_valid <= 1'b0;
      if (state == FILL) begin
        if (power_valid) begin
          if (fill_last) begin
            fill_cnt <= '0;
            state <= SWEEP;
            addr_active <= 1'b1;
          end else begin
            fill_cnt <= fill_cnt + 1'b1;
          end
        end
      end else if (energy_valid && energy_final) begin
        // frame done once the last filter energy has gone out.
        state <= FILL;
      end
      // counters run straight across filter boundaries.
      if (addr_active) begin
        if (addr_last) begin
          bin_cnt <= '0;
          if (addr_final) begin
            filt_cnt <= '0;
            addr_active <= 1'b0;
          end else begin
            filt_cnt <= filt_cnt + 1'b1;
          end
        end else begin
          bin_cnt <= bin_cnt + 1'b1;
        end
      end
      if (s2_valid) begin
        if (s2_last) begin
          acc <= '0;
          energy_valid <= 1'b1;
        end else begin
          acc <= acc_sum;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == FILL && power_valid) begin
      frame_buf[fill_cnt] <= power;
    end
    s1_power <= frame_buf[bin_cnt];
    s1_last <= addr_last;
    s1_final <= addr_final;
    s2_prod <= s1_power * coeff;
    s2_last <= s1_last;
    s2_final <= s1_final;
    if (s2_valid && s2_last) begin
      energy <= acc_sum[ACC_W-1:COEFF_FRAC];
      energy_final <= s2_final;
    end
  end

  // a low ready holds the source off, so no power shows up a cycle later.
  a_no_power_when_busy : assert property (
    @(posedge clk) disable iff (rst) !bin_ready |=> !power_valid
  );

  // energies only come out of a frame sweep.
  a_no_energy_in_fill : assert property (
    @(posedge clk) disable iff (rst) energy_valid |-> (state == SWEEP)
  );

endmodule

// File: verilog/log_compress.sv
`timescale 1ns/1ps

module log_compress (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [mel_pkg::ENERGY_W-1:0] energy,
  input  logic                         energy_valid,
  output logic [mel_pkg::ENERGY_W-1:0] mel_energy,
  output logic [mel_pkg::LOG_W-1:0]    mel_log,
  output logic                         mel_valid
);

  import mel_pkg::*;

  logic [LOG_INT_W-1:0] lead_pos;
  logic [LOG_INT_W-1:0] norm_shift;
  logic [ENERGY_W-1:0] norm;
  logic [LOG_FRAC-1:0] mant;

  // highest set bit wins, since later iterations overwrite earlier ones.
  always_comb begin
    lead_pos = '0;
    for (int i = 0; i < ENERGY_W; i++) begin
      if (energy[i]) begin
        lead_pos = LOG_INT_W'(i);
      end
    end
  end

  // normalize so the leading one sits at the top bit.
  assign norm_shift = LOG_INT_W'(ENERGY_W - 1) - lead_pos;
  assign norm = energy << norm_shift;

  // bits below the leading one; zeros shift in when the energy is short.
  assign mant = norm[ENERGY_W-2 -: LOG_FRAC];

  always_ff @(posedge clk) begin
    if (rst) begin
      mel_valid <= 1'b0;
    end else begin
      mel_valid <= energy_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (energy_valid) begin
      mel_energy <= energy;
      mel_log <= {lead_pos, mant};
    end
  end

  // integer part is the leading-one position inside the stored energy word.
  a_log_int_range : assert property (
    @(posedge clk) disable iff (rst)
      mel_valid |-> (int'(mel_log[LOG_W-1:LOG_FRAC]) < ENERGY_W) &&
        ((mel_energy >> mel_log[LOG_W-1:LOG_FRAC]) == ENERGY_W'(|mel_energy))
  );

endmodule

// File: verilog/mel_frontend.sv
`timescale 1ns/1ps

module mel_frontend #(
  parameter int NUM_FILTERS = 40,
  parameter int FILTER_SIZE = 23
) (
  input  logic                         clk,
  input  logic                         rst,
  input  mel_pkg::bin_word_t           bin_in,
  input  logic                         bin_mode,
  input  logic                         bin_valid,
  output logic                         bin_ready,
  output logic [mel_pkg::ENERGY_W-1:0] mel_energy,
  output logic [mel_pkg::LOG_W-1:0]    mel_log,
  output logic                         mel_valid
);

  import mel_pkg::*;

  logic [BIN_W-1:0] power;
  logic power_valid;
  logic [ENERGY_W-1:0] energy;
  logic energy_valid;

  // decode each bin into power.
  bin_power bin_power_inst (
    .clk        (clk),
    .rst        (rst),
    .bin_in     (bin_in),
    .bin_mode   (bin_mode),
    .bin_valid  (bin_valid),
    .power      (power),
    .power_valid(power_valid)
  );

  // frame store and per-filter accumulation.
  mel_filterbank #(
    .NUM_FILTERS(NUM_FILTERS),
    .FILTER_SIZE(FILTER_SIZE)
  ) mel_filterbank_inst (
    .clk         (clk),
    .rst         (rst),
    .power       (power),
    .power_valid (power_valid),
    .bin_ready   (bin_ready),
    .energy      (energy),
    .energy_valid(energy_valid)
  );

  // log2 of each energy, in filter order.
  log_compress log_compress_inst (
    .clk         (clk),
    .rst         (rst),
    .energy      (energy),
    .energy_valid(energy_valid),
    .mel_energy  (mel_energy),
    .mel_log     (mel_log),
    .mel_valid   (mel_valid)
  );

endmodule

// File: bench/mel_frontend_tb.sv
`timescale 1ns/1ps

module mel_frontend_tb;

  import mel_pkg::*;

  localparam int NUM_FILTERS = 40;
  localparam int FILTER_SIZE = 23;
  localparam int NUM_ROWS = 10;
  localparam int TOTAL_BINS = NUM_ROWS * FILTER_SIZE;
  localparam int TOTAL_OUT = NUM_ROWS * NUM_FILTERS;
  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DELAY = 5;
  localparam longint WATCHDOG_CYCLES = NUM_ROWS * (NUM_FILTERS + 2) * FILTER_SIZE * 4;

  // how the bins of one frame are filled.
  localparam logic [1:0] FILL_ZERO = 2'd0;
  localparam logic [1:0] FILL_CONST = 2'd1;
  localparam logic [1:0] FILL_RAMP = 2'd2;
  localparam logic [1:0] FILL_RANDOM = 2'd3;

  // for random rows, value is the number of lfsr bits per bin.
  typedef struct packed {
    logic mode;
    logic [1:0] kind;
    logic [31:0] value;
    logic from_model;
    logic [ENERGY_W-1:0] f0_energy;
  } row_t;

  logic clk;
  logic rst;
  bin_word_t bin_in;
  logic bin_mode;
  logic bin_valid;
  logic bin_ready;
  logic [ENERGY_W-1:0] mel_energy;
  logic [LOG_W-1:0] mel_log;
  logic mel_valid;

  row_t rows [NUM_ROWS];
  logic [BIN_W-1:0] bin_words [TOTAL_BINS];
  logic [BIN_W-1:0] bin_powers [TOTAL_BINS];
  logic [31:0] lfsr_state;
  int out_cnt = 0;
  int err_count = 0;
  int row_errs = 0;
  int check_count = 0;

  mel_frontend #(
    .NUM_FILTERS(NUM_FILTERS),
    .FILTER_SIZE(FILTER_SIZE)
  ) mel_frontend_inst (
    .clk       (clk),
    .rst       (rst),
    .bin_in    (bin_in),
    .bin_mode  (bin_mode),
    .bin_valid (bin_valid),
    .bin_ready (bin_ready),
    .mel_energy(mel_energy),
    .mel_log   (mel_log),
    .mel_valid (mel_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // 32-bit fibonacci lfsr, taps 32 22 2 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_random(input int nbits, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  // band edges and levels of the mel weighting.
  function automatic logic [COEFF_W-1:0] coeff_model(input int f, input int b);
    int peak_end;
    int mid_end;
    logic [COEFF_W-1:0] mid;
    logic [COEFF_W-1:0] tail;
    if (f < NUM_FILTERS / 4) begin
      peak_end = 10;
      mid_end = 20;
      mid = 16'h4000;
      tail = 16'h1000;
    end else if (f < (3 * NUM_FILTERS) / 4) begin
      peak_end = 5;
      mid_end = 15;
      mid = 16'h6000;
      tail = 16'h2000;
    end else begin
      peak_end = 3;
      mid_end = 8;
      mid = 16'h5000;
      tail = 16'h3000;
    end
    if (b < peak_end) begin
      return 16'h7FFF;
    end
    return (b < mid_end) ? mid : tail;
  endfunction

  function automatic logic [BIN_W-1:0] power_model(input logic mode, input logic [31:0] word);
    longint re_v;
    longint im_v;
    if (mode == MODE_POWER) begin
      return word;
    end
    re_v = longint'($signed(word[31:16]));
    im_v = longint'($signed(word[15:0]));
    return BIN_W'(re_v * re_v + im_v * im_v);
  endfunction

  function automatic logic [ENERGY_W-1:0] energy_model(input int row, input int f);
    logic [63:0] sum;
    sum = '0;
    for (int b = 0; b < FILTER_SIZE; b++) begin
      sum = sum + 64'(bin_powers[row * FILTER_SIZE + b]) * 64'(coeff_model(f, b));
    end
    return ENERGY_W'(sum >> COEFF_FRAC);
  endfunction

  // leading-one position, then the ten bits just below it.
  function automatic logic [LOG_W-1:0] log_model(input logic [ENERGY_W-1:0] e);
    int p;
    logic [ENERGY_W-1:0] m;
    p = -1;
    for (int i = ENERGY_W - 1; i >= 0; i--) begin
      if (e[i] && p < 0) begin
        p = i;
      end
    end
    if (p < 0) begin
      return '0;
    end
    if (p >= LOG_FRAC) begin
      m = e >> (p - LOG_FRAC);
    end else begin
      m = e << (LOG_FRAC - p);
    end
    return {LOG_INT_W'(p), m[LOG_FRAC-1:0]};
  endfunction

  function automatic string kind_name(input logic [1:0] kind);
    case (kind)
      FILL_ZERO: return "zero";
      FILL_CONST: return "constant";
      FILL_RAMP: return "ramp";
      default: return "random";
    endcase
  endfunction

  task automatic set_row(input int i, input logic mode, input logic [1:0] kind,
                         input logic [31:0] value, input logic from_model,
                         input logic [ENERGY_W-1:0] f0_energy);
    row_t r;
    r.mode = mode;
    r.kind = kind;
    r.value = value;
    r.from_model = from_model;
    r.f0_energy = f0_energy;
    rows[i] = r;
  endtask

  // filter 0 values are worked by hand for a 23-bin frame.
  task automatic load_table();
    set_row(0, MODE_POWER, FILL_ZERO, 32'd0, 1'b0, 40'd0);
    set_row(1, MODE_POWER, FILL_CONST, 32'd32768, 1'b0, 40'd503798);
    set_row(2, MODE_COMPLEX, FILL_CONST, 32'h0003_0004, 1'b0, 40'd384);
    set_row(3, MODE_COMPLEX, FILL_CONST, 32'h8000_8000, 1'b0, 40'd33016905728);
    set_row(4, MODE_COMPLEX, FILL_RAMP, 32'h0010_0000, 1'b1, 40'd0);
    set_row(5, MODE_POWER, FILL_RAMP, 32'd0, 1'b1, 40'd0);
    set_row(6, MODE_POWER, FILL_RANDOM, 32'd32, 1'b1, 40'd0);
    set_row(7, MODE_POWER, FILL_RANDOM, 32'd4, 1'b1, 40'd0);
    set_row(8, MODE_POWER, FILL_RANDOM, 32'd12, 1'b1, 40'd0);
    set_row(9, MODE_COMPLEX, FILL_RANDOM, 32'd32, 1'b1, 40'd0);
  endtask

  task automatic build_frames();
    logic [31:0] word;
    int k;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int b = 0; b < FILTER_SIZE; b++) begin
        k = r * FILTER_SIZE + b;
        case (rows[r].kind)
          FILL_ZERO: word = '0;
          FILL_CONST: word = rows[r].value;
          FILL_RAMP: word = rows[r].value + 32'(b);
          default: take_random(int'(rows[r].value), word);
        endcase
        bin_words[k] = word;
        bin_powers[k] = power_model(rows[r].mode, word);
      end
    end
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    check_count++;
    if (got !== expected) begin
      err_count++;
      row_errs++;
      $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
    end
  endtask

  // frames go out back to back, each bin only while ready is high.
  task automatic drive_bins();
    int idx;
    idx = 0;
    while (idx < TOTAL_BINS) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (bin_ready) begin
        bin_in.pwr = bin_words[idx];
        bin_mode = rows[idx / FILTER_SIZE].mode;
        bin_valid = 1'b1;
        idx++;
      end else begin
        bin_valid = 1'b0;
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    bin_valid = 1'b0;
  endtask

  task automatic check_output(input int k);
    int row;
    int f;
    logic [ENERGY_W-1:0] exp_e;
    row = k / NUM_FILTERS;
    f = k % NUM_FILTERS;
    if (f == 0 && !rows[row].from_model) begin
      exp_e = rows[row].f0_energy;
    end else begin
      exp_e = energy_model(row, f);
    end
    check_value($sformatf("row %0d filter %0d energy", row, f), 64'(mel_energy), 64'(exp_e));
    check_value($sformatf("row %0d filter %0d log", row, f), 64'(mel_log), 64'(log_model(exp_e)));
    if (f == NUM_FILTERS - 1) begin
      $display("row %0d: %s mode, %s fill, %0d filters, %0d mismatches", row,
               (rows[row].mode == MODE_COMPLEX) ? "complex" : "power",
               kind_name(rows[row].kind), NUM_FILTERS, row_errs);
      row_errs = 0;
    end
  endtask

  // outputs are sampled away from the driving edge.
  always @(negedge clk) begin
    if (!rst && mel_valid) begin
      if (out_cnt < TOTAL_OUT) begin
        check_output(out_cnt);
      end else begin
        err_count++;
        $display("extra mel output at %0t after all frames were checked", $time);
      end
      out_cnt++;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles with %0d of %0d mel outputs seen",
             WATCHDOG_CYCLES, out_cnt, TOTAL_OUT);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    rst = 1'b1;
    bin_in = '0;
    bin_mode = MODE_POWER;
    bin_valid = 1'b0;
    lfsr_state = 32'h63dc;
    load_table();
    build_frames();
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    check_value("bin_ready after reset", 64'(bin_ready), 64'd1);
    check_value("mel_valid after reset", 64'(mel_valid), 64'd0);
    drive_bins();
    wait (out_cnt >= TOTAL_OUT);
    // idle a while so late or extra outputs still show up.
    repeat (2 * FILTER_SIZE) @(posedge clk);
    #DRIVE_DELAY;
    check_value("bin_ready after last frame", 64'(bin_ready), 64'd1);
    check_value("mel output count", 64'(out_cnt), 64'(TOTAL_OUT));
    $display("rows %0d, outputs %0d, checks %0d, errors %0d",
             NUM_ROWS, out_cnt, check_count, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
common/mel_pkg.sv
verilog/bin_power.sv
mel_filterbank/mel_coeff_rom.sv
mel_filterbank/mel_filterbank.sv
verilog/log_compress.sv
verilog/mel_frontend.sv
bench/mel_frontend_tb.sv
